//--- src.f
design/conv1x1_pkg.sv
design/pixel_gather.sv
design/weight_ram.sv
design/weight_bus_arbiter.sv
design/channel_mac.sv
design/out_fifo.sv
design/conv1x1_layer.sv
testbench/conv1x1_tb.sv

//--- run.sh
#!/bin/sh
cd "$(dirname "$0")" \
  && verilator --binary --assert -Wno-fatal -f src.f --top-module conv1x1_tb -Mdir obj_dir \
  && ./obj_dir/Vconv1x1_tb | tee /dev/stderr | grep -q "TEST OK" \
  && echo "simulation passed" \
  || { echo "simulation failed"; exit 1; }

//--- testbench/conv1x1_tb.sv
`timescale 1ns/1ps
`default_nettype none

module conv1x1_tb;

  typedef struct packed {
    conv1x1_pkg::pixel_vec_t samples;
    logic [31:0]             stall;
    logic                    readback;
    logic                    rewrite;
  } row_t;

  logic                               clk = 1'b0;
  logic                               reset;
  logic                               in_valid;
  logic [conv1x1_pkg::DATA_WIDTH-1:0] in_data;
  logic                               in_ready;
  conv1x1_pkg::wb_req_t               host_req;
  conv1x1_pkg::wb_rsp_t               host_rsp;
  logic                               out_valid;
  logic [conv1x1_pkg::DATA_WIDTH-1:0] out_data;
  logic                               out_ready = 1'b1;

  row_t        rows [$];
  string       names [$];
  logic [15:0] exp_q [$];
  string       name_q [$];
  logic [15:0] w_model [conv1x1_pkg::WEIGHT_DEPTH];
  logic [15:0] data_lfsr = 16'd41;
  logic [15:0] stall_lfsr = 16'd41;
  logic [31:0] cur_stall = '0;
  int          checks = 0;
  int          errors = 0;
  int          cycles = 0;

  conv1x1_layer dut_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .host_req  (host_req),
    .host_rsp  (host_rsp),
    .out_valid (out_valid),
    .out_data  (out_data),
    .out_ready (out_ready)
  );

  always #5 clk = ~clk;

  //////////////////////////////////////////////////
  // Random source and reference model
  //////////////////////////////////////////////////

  // x^16 + x^14 + x^13 + x^11 + 1
  function automatic logic [15:0] lfsr_next(input logic [15:0] st);
    return {st[14:0], st[15] ^ st[13] ^ st[12] ^ st[10]};
  endfunction

  function automatic logic [15:0] data_bits(input int n);
    logic [15:0] v;
    v = '0;
    for (int b = 0; b < n; b++) begin
      data_lfsr = lfsr_next(data_lfsr);
      v = {v[14:0], data_lfsr[0]};
    end
    return v;
  endfunction

  // Roughly +-8.0 in Q8.8
  function automatic logic [15:0] rand_sample();
    logic [15:0] v;
    v = data_bits(12);
    return {{4{v[11]}}, v[11:0]};
  endfunction

  function automatic logic [15:0] ref_word(input conv1x1_pkg::pixel_vec_t px, input int o);
    longint sum;
    longint top;
    top = (longint'(1) <<< (conv1x1_pkg::DATA_WIDTH - 1)) - 1;
    sum = 0;
    for (int i = 0; i < conv1x1_pkg::CHANNEL_IN; i++) begin
      sum += longint'($signed(px[i])) *
             longint'($signed(w_model[o * conv1x1_pkg::CHANNEL_IN + i]));
    end
    sum = sum >>> conv1x1_pkg::FRAC_BITS;
    if (sum > top) return top[15:0];
    if (sum < -top - 1) return 16'(-top - 1);
    return sum[15:0];
  endfunction

  //////////////////////////////////////////////////
  // Checks and bus tasks
  //////////////////////////////////////////////////

  task automatic check_word(input string name, input logic [15:0] exp, input logic [15:0] act);
    checks++;
    assert (act === exp) else begin
      $display("FAIL %s: expected %h, actual %h", name, exp, act);
      errors++;
    end
  endtask

  task automatic report_and_finish();
    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST OK");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  endtask

  // Wishbone classic single access, called on a falling edge
  task automatic host_access(input logic we, input logic [conv1x1_pkg::WADR_WIDTH-1:0] adr,
                             input logic [15:0] wdat, output logic [15:0] rdat);
    host_req.cyc = 1'b1;
    host_req.stb = 1'b1;
    host_req.we  = we;
    host_req.adr = adr;
    host_req.dat = wdat;
    @(negedge clk);
    while (!host_rsp.ack) @(negedge clk);
    rdat = host_rsp.dat;
    host_req = '0;
    @(negedge clk);
    checks++;
    assert (!host_rsp.ack) else begin
      $display("ERROR: host ack stayed high a second cycle at address %0d", adr);
      errors++;
    end
  endtask

  task automatic check_readback(input string name);
    logic [15:0] got;
    int          adr;
    for (int k = 0; k < 2; k++) begin
      adr = int'(data_bits(4)) % conv1x1_pkg::WEIGHT_DEPTH;
      host_access(1'b0, conv1x1_pkg::WADR_WIDTH'(adr), 16'h0000, got);
      check_word({name, "_readback"}, w_model[adr], got);
    end
  endtask

  task automatic rewrite_weights();
    logic [15:0] got;
    host_access(1'b1, 4'd0, 16'hFE00, got);
    w_model[0] = 16'hFE00;
    host_access(1'b1, 4'd3, 16'h0040, got);
    w_model[3] = 16'h0040;
    host_access(1'b1, 4'd5, 16'hFF40, got);
    w_model[5] = 16'hFF40;
  endtask

  task automatic send_pixel(input conv1x1_pkg::pixel_vec_t px);
    for (int i = 0; i < conv1x1_pkg::CHANNEL_IN; i++) begin
      in_valid = 1'b1;
      in_data  = px[i];
      while (!in_ready) @(negedge clk);
      @(negedge clk);
    end
    in_valid = 1'b0;
  endtask

  task automatic push_expected(input conv1x1_pkg::pixel_vec_t px, input string name);
    for (int o = 0; o < conv1x1_pkg::CHANNEL_OUT; o++) begin
      exp_q.push_back(ref_word(px, o));
      name_q.push_back(name);
    end
  endtask

  // Changed on a rising edge so the output monitor never races it
  task automatic set_stall(input logic [31:0] mask);
    @(posedge clk);
    cur_stall = mask;
    @(negedge clk);
  endtask

  task automatic drain_outputs();
    while (exp_q.size() != 0) @(posedge clk);
    @(negedge clk);
  endtask

  //////////////////////////////////////////////////
  // Stimulus table
  //////////////////////////////////////////////////

  task automatic add_row(input string name, input logic [15:0] s0, input logic [15:0] s1,
                         input logic [15:0] s2, input logic [15:0] s3,
                         input logic [31:0] stall, input logic rb, input logic rw);
    row_t row;
    row.samples[0] = s0;
    row.samples[1] = s1;
    row.samples[2] = s2;
    row.samples[3] = s3;
    row.stall      = stall;
    row.readback   = rb;
    row.rewrite    = rw;
    rows.push_back(row);
    names.push_back(name);
  endtask

  task automatic add_rand_row(input string name, input logic [31:0] stall, input logic rb);
    row_t row;
    for (int i = 0; i < conv1x1_pkg::CHANNEL_IN; i++) begin
      row.samples[i] = rand_sample();
    end
    row.stall    = stall;
    row.readback = rb;
    row.rewrite  = 1'b0;
    rows.push_back(row);
    names.push_back(name);
  endtask

  task automatic build_table();
    add_row("unit_basic", 16'h0100, 16'h0200, 16'h0300, 16'h0400, 32'h0, 1'b0, 1'b0);
    add_row("frac_mix", 16'h0080, 16'hFF80, 16'h0140, 16'h0010, 32'h0, 1'b1, 1'b0);
    add_row("sat_pos", 16'h7000, 16'h7000, 16'h7000, 16'h7000, 32'h0000_FFFF, 1'b0, 1'b0);
    add_row("sat_neg", 16'h9000, 16'h9000, 16'h9000, 16'h9000, 32'h0000_FFFF, 1'b0, 1'b0);
    add_rand_row("rand_light", 32'h0F0F_0F0F, 1'b1);
    // Near-constant stall so the FIFO fills and back-pressure reaches the input
    add_rand_row("rand_heavy_a", 32'hFFFF_FFFE, 1'b0);
    add_rand_row("rand_heavy_b", 32'hFFFF_FFFE, 1'b0);
    add_row("readback_busy", 16'h0100, 16'hFF00, 16'h0080, 16'h0200, 32'hFFFF_FFFE, 1'b1, 1'b0);
    add_rand_row("rand_heavy_c", 32'hFFFF_FFFE, 1'b0);
    add_row("after_rewrite", 16'h0100, 16'h0200, 16'h0300, 16'h0400, 32'h0, 1'b0, 1'b1);
  endtask

  //////////////////////////////////////////////////
  // Output monitor and run control
  //////////////////////////////////////////////////

  always @(negedge clk) begin
    logic [4:0]  idx;
    logic [15:0] exp_word;
    string       exp_name;
    for (int b = 0; b < 5; b++) begin
      stall_lfsr = lfsr_next(stall_lfsr);
      idx[b] = stall_lfsr[0];
    end
    out_ready = !cur_stall[idx];
    if (!reset && out_valid && out_ready) begin
      assert (exp_q.size() != 0) else begin
        $display("ERROR: output word %h arrived with no expected value pending", out_data);
        errors++;
      end
      if (exp_q.size() != 0) begin
        exp_word = exp_q.pop_front();
        exp_name = name_q.pop_front();
        check_word(exp_name, exp_word, out_data);
      end
    end
  end

  initial begin
    while (cycles < rows.size() * (conv1x1_pkg::CHANNEL_OUT * conv1x1_pkg::CHANNEL_IN * 4 + 40)
                    + conv1x1_pkg::WEIGHT_DEPTH * 8) begin
      @(posedge clk);
      cycles++;
    end
    $display("ERROR: run timed out after %0d cycles", cycles);
    errors++;
    report_and_finish();
  end

  initial begin
    logic [15:0] got;
    reset    = 1'b1;
    in_valid = 1'b0;
    in_data  = '0;
    host_req = '0;
    build_table();
    w_model = '{16'h0100, 16'h0080, 16'hFFC0, 16'h0200,
                16'hFF00, 16'h00C0, 16'h0180, 16'h0020,
                16'h0300, 16'h0200, 16'h0400, 16'h0100};
    repeat (2) @(negedge clk);
    reset = 1'b0;
    check_word("reset_out_valid", 16'd0, {15'd0, out_valid});
    check_word("reset_in_ready", 16'd1, {15'd0, in_ready});

    for (int a = 0; a < conv1x1_pkg::WEIGHT_DEPTH; a++) begin
      host_access(1'b1, conv1x1_pkg::WADR_WIDTH'(a), w_model[a], got);
    end
    for (int a = 0; a < conv1x1_pkg::WEIGHT_DEPTH; a++) begin
      host_access(1'b0, conv1x1_pkg::WADR_WIDTH'(a), 16'h0000, got);
      check_word("weight_load", w_model[a], got);
    end

    for (int r = 0; r < rows.size(); r++) begin
      set_stall(rows[r].stall);
      if (rows[r].rewrite) begin
        // Earlier pixels must finish on the old weights
        drain_outputs();
        rewrite_weights();
      end
      push_expected(rows[r].samples, names[r]);
      fork
        send_pixel(rows[r].samples);
        begin
          if (rows[r].readback) begin
            check_readback(names[r]);
          end
        end
      join
    end

    set_stall(32'h0);
    drain_outputs();
    // Quiet period to catch any repeated word
    repeat (2 * conv1x1_pkg::CHANNEL_IN + 10) @(negedge clk);
    report_and_finish();
  end

endmodule

`default_nettype wire

//--- design/conv1x1_layer.sv
`timescale 1ns/1ps
`default_nettype none

module conv1x1_layer (
  input  wire                                clk,
  input  wire                                reset,
  input  wire                                in_valid,
  input  wire  [conv1x1_pkg::DATA_WIDTH-1:0] in_data,
  output logic                               in_ready,
  input  wire  conv1x1_pkg::wb_req_t         host_req,
  output conv1x1_pkg::wb_rsp_t               host_rsp,
  output logic                               out_valid,
  output logic [conv1x1_pkg::DATA_WIDTH-1:0] out_data,
  input  wire                                out_ready
);

  //////////////////////////////////////////////////
  // Internal links
  //////////////////////////////////////////////////

  logic                               pix_valid;
  logic                               pix_ready;
  conv1x1_pkg::pixel_vec_t            pix;

  conv1x1_pkg::wb_req_t               mac_req;
  conv1x1_pkg::wb_rsp_t               mac_rsp;
  conv1x1_pkg::wb_req_t               ram_req;
  conv1x1_pkg::wb_rsp_t               ram_rsp;

  logic                               res_valid;
  logic                               res_ready;
  logic [conv1x1_pkg::DATA_WIDTH-1:0] res_data;

  pixel_gather gather_i (
    .clk       (clk),
    .reset     (reset),
    .in_valid  (in_valid),
    .in_data   (in_data),
    .in_ready  (in_ready),
    .pix_valid (pix_valid),
    .pix       (pix),
    .pix_ready (pix_ready)
  );

  channel_mac mac_i (
    .clk       (clk),
    .reset     (reset),
    .pix_valid (pix_valid),
    .pix       (pix),
    .pix_ready (pix_ready),
    .mac_req   (mac_req),
    .mac_rsp   (mac_rsp),
    .res_valid (res_valid),
    .res_data  (res_data),
    .res_ready (res_ready)
  );

  // Host and MAC share the single weight port
  weight_bus_arbiter arbiter_i (
    .clk      (clk),
    .reset    (reset),
    .host_req (host_req),
    .host_rsp (host_rsp),
    .mac_req  (mac_req),
    .mac_rsp  (mac_rsp),
    .ram_req  (ram_req),
    .ram_rsp  (ram_rsp)
  );

  weight_ram ram_i (
    .clk   (clk),
    .reset (reset),
    .req   (ram_req),
    .rsp   (ram_rsp)
  );

  out_fifo #(
    .DEPTH (conv1x1_pkg::FIFO_DEPTH)
  ) fifo_i (
    .clk      (clk),
    .reset    (reset),
    .wr_valid (res_valid),
    .wr_data  (res_data),
    .wr_ready (res_ready),
    .rd_valid (out_valid),
    .rd_data  (out_data),
    .rd_ready (out_ready)
  );

endmodule

`default_nettype wire

//--- design/out_fifo.sv
`timescale 1ns/1ps
`default_nettype none

module out_fifo #(
  parameter int DEPTH = conv1x1_pkg::FIFO_DEPTH
) (
  input  wire                                clk,
  input  wire                                reset,
  input  wire                                wr_valid,
  input  wire  [conv1x1_pkg::DATA_WIDTH-1:0] wr_data,
  output logic                               wr_ready,
  output logic                               rd_valid,
  output logic [conv1x1_pkg::DATA_WIDTH-1:0] rd_data,
  input  wire                                rd_ready
);

  localparam int PW = $clog2(DEPTH);

  logic [conv1x1_pkg::DATA_WIDTH-1:0] mem [DEPTH];
  logic [PW-1:0]                      wr_ptr;
  logic [PW-1:0]                      rd_ptr;
  logic [PW:0]                        count;
  logic                               push;
  logic                               pop;

  assign wr_ready = (count != DEPTH);
  assign rd_valid = (count != 0);
  // Head word is visible without a read strobe
  assign rd_data  = mem[rd_ptr];

  assign push = wr_valid && wr_ready;
  assign pop  = rd_valid && rd_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      if (push && !pop) begin
        count <= count + 1'b1;
      end else if (pop && !push) begin
        count <= count - 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      mem[wr_ptr] <= wr_data;
    end
  end

endmodule

`default_nettype wire

//--- design/channel_mac.sv
`timescale 1ns/1ps
`default_nettype none

module channel_mac (
  input  wire                                clk,
  input  wire                                reset,
  input  wire                                pix_valid,
  input  wire  conv1x1_pkg::pixel_vec_t      pix,
  output logic                               pix_ready,
  output conv1x1_pkg::wb_req_t               mac_req,
  input  wire  conv1x1_pkg::wb_rsp_t         mac_rsp,
  output logic                               res_valid,
  output logic [conv1x1_pkg::DATA_WIDTH-1:0] res_data,
  input  wire                                res_ready
);

  localparam int AW = conv1x1_pkg::ACC_WIDTH;
  localparam int DW = conv1x1_pkg::DATA_WIDTH;

  conv1x1_pkg::mac_state_t                     state;
  conv1x1_pkg::pixel_vec_t                     pix_q;
  logic [$clog2(conv1x1_pkg::CHANNEL_OUT)-1:0] o_cnt;
  logic [$clog2(conv1x1_pkg::CHANNEL_IN)-1:0]  i_cnt;
  logic signed [AW-1:0]                        acc;
  logic signed [AW-1:0]                        product;
  logic signed [AW-1:0]                        scaled;
  logic [AW-DW:0]                              upper;
  logic                                        busy;

  //////////////////////////////////////////////////
  // Weight fetch
  //////////////////////////////////////////////////

  // cyc stays up over the reads of one output channel
  assign busy = (state == conv1x1_pkg::MAC_REQ) || (state == conv1x1_pkg::MAC_WAIT);

  always_comb begin
    mac_req     = '0;
    mac_req.cyc = busy;
    mac_req.stb = busy;
    mac_req.adr = conv1x1_pkg::WADR_WIDTH'(o_cnt * conv1x1_pkg::CHANNEL_IN + i_cnt);
  end

  // Sign extended to the accumulator width before multiplying
  assign product = $signed(mac_rsp.dat) * $signed(pix_q[i_cnt]);

  //////////////////////////////////////////////////
  // Control
  //////////////////////////////////////////////////

  assign pix_ready = (state == conv1x1_pkg::MAC_IDLE);

  always_ff @(posedge clk) begin
    if (reset) begin
      state <= conv1x1_pkg::MAC_IDLE;
      o_cnt <= '0;
      i_cnt <= '0;
    end else begin
      case (state)
        conv1x1_pkg::MAC_IDLE: begin
          if (pix_valid) begin
            state <= conv1x1_pkg::MAC_REQ;
          end
        end
        conv1x1_pkg::MAC_REQ: begin
          state <= conv1x1_pkg::MAC_WAIT;
        end
        conv1x1_pkg::MAC_WAIT: begin
          if (mac_rsp.ack) begin
            if (i_cnt == conv1x1_pkg::CHANNEL_IN - 1) begin
              i_cnt <= '0;
              state <= conv1x1_pkg::MAC_PUSH;
            end else begin
              i_cnt <= i_cnt + 1'b1;
              state <= conv1x1_pkg::MAC_REQ;
            end
          end
        end
        conv1x1_pkg::MAC_PUSH: begin
          if (res_ready) begin
            if (o_cnt == conv1x1_pkg::CHANNEL_OUT - 1) begin
              o_cnt <= '0;
              state <= conv1x1_pkg::MAC_IDLE;
            end else begin
              o_cnt <= o_cnt + 1'b1;
              state <= conv1x1_pkg::MAC_REQ;
            end
          end
        end
        default: state <= conv1x1_pkg::MAC_IDLE;
      endcase
    end
  end

  // Datapath registers
  always_ff @(posedge clk) begin
    if (pix_valid && pix_ready) begin
      pix_q <= pix;
      acc   <= '0;
    end else if (state == conv1x1_pkg::MAC_WAIT && mac_rsp.ack) begin
      acc <= acc + product;
    end else if (state == conv1x1_pkg::MAC_PUSH && res_ready) begin
      acc <= '0;
    end
  end

  //////////////////////////////////////////////////
  // Scale and saturate
  //////////////////////////////////////////////////

  assign scaled = acc >>> conv1x1_pkg::FRAC_BITS;
  assign upper  = scaled[AW-1:DW-1];

  always_comb begin
    // Fits when every bit above the result sign matches it
    if (&upper || !(|upper)) begin
      res_data = scaled[DW-1:0];
    end else if (scaled[AW-1]) begin
      res_data = {1'b1, {(DW-1){1'b0}}};
    end else begin
      res_data = {1'b0, {(DW-1){1'b1}}};
    end
  end

  assign res_valid = (state == conv1x1_pkg::MAC_PUSH);

endmodule

`default_nettype wire

//--- design/weight_bus_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module weight_bus_arbiter (
  input  wire                  clk,
  input  wire                  reset,
  input  wire  conv1x1_pkg::wb_req_t host_req,
  output conv1x1_pkg::wb_rsp_t host_rsp,
  input  wire  conv1x1_pkg::wb_req_t mac_req,
  output conv1x1_pkg::wb_rsp_t mac_rsp,
  output conv1x1_pkg::wb_req_t ram_req,
  input  wire  conv1x1_pkg::wb_rsp_t ram_rsp
);

  conv1x1_pkg::grant_t gnt_q;
  conv1x1_pkg::grant_t sel;
  logic                held_q;
  logic                last_mac_q;
  logic                owner_cyc;
  logic                keep;

  //////////////////////////////////////////////////
  // Grant selection
  //////////////////////////////////////////////////

  always_comb begin
    owner_cyc = (gnt_q == conv1x1_pkg::GNT_MAC) ? mac_req.cyc : host_req.cyc;
    keep      = held_q && owner_cyc;
    if (keep) begin
      sel = gnt_q;
    end else if (host_req.cyc && mac_req.cyc) begin
      // Both new at once, serve whoever went second last time
      sel = last_mac_q ? conv1x1_pkg::GNT_HOST : conv1x1_pkg::GNT_MAC;
    end else if (mac_req.cyc) begin
      sel = conv1x1_pkg::GNT_MAC;
    end else begin
      sel = conv1x1_pkg::GNT_HOST;
    end
  end

  assign ram_req = (sel == conv1x1_pkg::GNT_MAC) ? mac_req : host_req;

  // gnt_q is the owner of the access whose ack shows this cycle
  always_ff @(posedge clk) begin
    if (reset) begin
      gnt_q      <= conv1x1_pkg::GNT_HOST;
      held_q     <= 1'b0;
      last_mac_q <= 1'b0;
    end else begin
      gnt_q  <= sel;
      held_q <= ram_req.cyc;
      if (ram_req.cyc && !keep) begin
        last_mac_q <= (sel == conv1x1_pkg::GNT_MAC);
      end
    end
  end

  //////////////////////////////////////////////////
  // Response routing
  //////////////////////////////////////////////////

  assign host_rsp.dat = ram_rsp.dat;
  assign host_rsp.ack = ram_rsp.ack && (gnt_q == conv1x1_pkg::GNT_HOST);
  assign mac_rsp.dat  = ram_rsp.dat;
  assign mac_rsp.ack  = ram_rsp.ack && (gnt_q == conv1x1_pkg::GNT_MAC);

endmodule

`default_nettype wire

//--- design/weight_ram.sv
`timescale 1ns/1ps
`default_nettype none

module weight_ram (
  input  wire                  clk,
  input  wire                  reset,
  input  wire  conv1x1_pkg::wb_req_t req,
  output conv1x1_pkg::wb_rsp_t rsp
);

  logic [conv1x1_pkg::DATA_WIDTH-1:0] mem [conv1x1_pkg::WEIGHT_DEPTH];
  logic [conv1x1_pkg::DATA_WIDTH-1:0] rd_data;
  logic                               ack;
  logic                               access;

  // No new access in the ack cycle, so ack never lasts two cycles
  assign access = req.cyc && req.stb && !ack;

  always_ff @(posedge clk) begin
    if (reset) begin
      ack <= 1'b0;
    end else begin
      ack <= access;
    end
  end

  always_ff @(posedge clk) begin
    if (access) begin
      if (req.we) begin
        mem[req.adr] <= req.dat;
      end
      rd_data <= mem[req.adr];
    end
  end

  assign rsp.dat = rd_data;
  assign rsp.ack = ack;

endmodule

`default_nettype wire

//--- design/pixel_gather.sv
`timescale 1ns/1ps
`default_nettype none

module pixel_gather (
  input  wire                                clk,
  input  wire                                reset,
  input  wire                                in_valid,
  input  wire  [conv1x1_pkg::DATA_WIDTH-1:0] in_data,
  output logic                               in_ready,
  output logic                               pix_valid,
  output conv1x1_pkg::pixel_vec_t            pix,
  input  wire                                pix_ready
);

  logic [$clog2(conv1x1_pkg::CHANNEL_IN)-1:0] ch_cnt;
  logic                                       take;

  // Stall the input while a full vector waits for the MAC
  assign in_ready = !pix_valid;
  assign take     = in_valid && in_ready;

  always_ff @(posedge clk) begin
    if (reset) begin
      ch_cnt    <= '0;
      pix_valid <= 1'b0;
    end else begin
      if (pix_valid && pix_ready) begin
        pix_valid <= 1'b0;
      end
      if (take) begin
        if (ch_cnt == conv1x1_pkg::CHANNEL_IN - 1) begin
          ch_cnt    <= '0;
          pix_valid <= 1'b1;
        end else begin
          ch_cnt <= ch_cnt + 1'b1;
        end
      end
    end
  end

  // Sample store, one slot per input channel
  always_ff @(posedge clk) begin
    if (take) begin
      pix[ch_cnt] <= in_data;
    end
  end

endmodule

`default_nettype wire

//--- design/conv1x1_pkg.sv
`default_nettype none

package conv1x1_pkg;

  //////////////////////////////////////////////////
  // Sizes
  //////////////////////////////////////////////////

  // Q8.8 samples and weights
  localparam int DATA_WIDTH   = 16;
  localparam int FRAC_BITS    = 8;

  localparam int CHANNEL_IN   = 4;
  localparam int CHANNEL_OUT  = 3;
  localparam int WEIGHT_DEPTH = CHANNEL_IN * CHANNEL_OUT;
  localparam int WADR_WIDTH   = 4;

  // Full product width plus headroom for the channel sum
  localparam int ACC_WIDTH    = 2 * DATA_WIDTH + 2;
  localparam int FIFO_DEPTH   = 8;

  //////////////////////////////////////////////////
  // Bus and stream types
  //////////////////////////////////////////////////

  typedef struct packed {
    logic                  cyc;
    logic                  stb;
    logic                  we;
    logic [WADR_WIDTH-1:0] adr;
    logic [DATA_WIDTH-1:0] dat;
  } wb_req_t;

  typedef struct packed {
    logic [DATA_WIDTH-1:0] dat;
    logic                  ack;
  } wb_rsp_t;

  // Channel 0 sits in the low slice
  typedef logic signed [CHANNEL_IN-1:0][DATA_WIDTH-1:0] pixel_vec_t;

  typedef enum logic [1:0] {
    MAC_IDLE,
    MAC_REQ,
    MAC_WAIT,
    MAC_PUSH
  } mac_state_t;

  typedef enum logic {
    GNT_HOST,
    GNT_MAC
  } grant_t;

endpackage

`default_nettype wire
